// ==== Bender.yml ====
package:
  name: dcache

sources:
  - target: any(rtl, test)
    files:
      - hw/dcache_geom_pkg.sv
      - hw/dcache_bus_pkg.sv
      - hw/line_regs.sv
      - hw/data_sram.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_top.sv
  - target: test
    files:
      - dv/dcache_chk.sv
      - dv/dcache_tb.sv

// ==== dcache_top.f ====
hw/dcache_geom_pkg.sv
hw/dcache_bus_pkg.sv
hw/line_regs.sv
hw/data_sram.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/dcache_chk.sv
dv/dcache_tb.sv

// ==== dv/dcache_chk.sv ====
`timescale 1ns/100ps

// protocol checks on the cache controller
module dcache_chk (
    input logic                               clk,
    input logic                               rst,
    input dcache_bus_pkg::ctrl_state_t        state_i,
    input logic                               req_valid_i,
    input logic                               req_ready_i,
    input logic                               resp_valid_i,
    input logic                               mem_req_valid_i,
    input logic                               mem_req_ready_i,
    input logic                               mem_req_write_i,
    input logic [dcache_geom_pkg::ADDR_W-1:0] mem_req_addr_i,
    input logic [dcache_geom_pkg::LINE_W-1:0] mem_req_wdata_i
);

    int fail_count = 0;  // failed assertions so far

    // a stalled memory command keeps valid and all its fields
    mem_cmd_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_write_i)
            && $stable(mem_req_addr_i) && $stable(mem_req_wdata_i))
        else begin
            fail_count++;
            $error("memory command dropped or changed while stalled");
        end

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        resp_valid_i |=> !resp_valid_i)
        else begin
            fail_count++;
            $error("response valid held for two cycles");
        end

    // an accepted request leaves idle, so ready drops with it
    ready_in_idle: assert property (@(posedge clk) disable iff (rst)
        req_valid_i && req_ready_i |=> !req_ready_i && (state_i != dcache_bus_pkg::IDLE))
        else begin
            fail_count++;
            $error("request ready still high after an accepted request");
        end

    out_of_reset: assert property (@(posedge clk)
        rst |=> req_ready_i && !resp_valid_i && !mem_req_valid_i)
        else begin
            fail_count++;
            $error("wrong handshake outputs right after reset");
        end

endmodule

// ==== dv/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

    localparam int N_ACCESS = 400;
    localparam int N_TAGS   = 6;
    localparam int N_SETS   = 4;                      // sets 0..3 only, lots of evictions
    localparam int N_BYTES  = N_TAGS * N_SETS * 16;

    logic                               clk;
    logic                               rst;
    logic                               req_valid_i;
    logic                               req_ready_o;
    logic                               req_write_i;
    logic [dcache_geom_pkg::ADDR_W-1:0] req_addr_i;
    logic [dcache_bus_pkg::DATA_W-1:0]  req_wdata_i;
    logic [dcache_bus_pkg::STRB_W-1:0]  req_strb_i;
    logic                               resp_valid_o;
    logic [dcache_bus_pkg::DATA_W-1:0]  resp_rdata_o;
    logic                               mem_req_valid_o;
    logic                               mem_req_ready_i;
    logic                               mem_req_write_o;
    logic [dcache_geom_pkg::ADDR_W-1:0] mem_req_addr_o;
    logic [dcache_geom_pkg::LINE_W-1:0] mem_req_wdata_o;
    logic                               mem_resp_valid_i;
    logic [dcache_geom_pkg::LINE_W-1:0] mem_resp_rdata_i;

    logic [7:0]                  model_mem [N_BYTES];  // what the cpu should see
    logic [7:0]                  ram [N_BYTES];        // responder backing store
    dcache_geom_pkg::tag_entry_t shadow [N_SETS][2];
    dcache_geom_pkg::way_t       mru [N_SETS];
    logic [31:0]                 cpu_seed;
    logic [31:0]                 mem_seed;
    logic                        cmd_write_q [$];      // accepted memory commands, in order
    logic [31:0]                 cmd_addr_q [$];
    int                          resp_delay;           // -1 when no refill is pending
    logic                        stalled;
    int                          errors;
    int                          checks;
    bit                          stop;

    dcache_top #(.SETS_P(dcache_geom_pkg::SETS)) dcache_top_i (.*);

    bind dcache_ctrl dcache_chk chk_i (
        .clk (clk), .rst (rst), .state_i (state_q),
        .req_valid_i (req_valid_i),
        .req_ready_i (req_ready_o), .resp_valid_i (resp_valid_o),
        .mem_req_valid_i (mem_req_valid_o), .mem_req_ready_i (mem_req_ready_i),
        .mem_req_write_i (mem_req_write_o), .mem_req_addr_i (mem_req_addr_o),
        .mem_req_wdata_i (mem_req_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state[31:16];  // low bits of an lcg are weak
    endfunction

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[31:24] ^ a[23:16] ^ (a[15:8] * 8'd29) ^ (a[7:0] * 8'd13);
    endfunction

    // tag, set and offset packed into the small test memories
    function automatic int byte_index(input logic [31:0] a);
        return int'(a[31:11]) * 64 + int'(a[10:4]) * 16 + int'(a[3:0]);
    endfunction

    function automatic logic [127:0] get_line(input logic [7:0] m [N_BYTES], input int base);
        logic [127:0] line;
        for (int b = 0; b < 16; b++) begin
            line[b*8 +: 8] = m[base + b];
        end
        return line;
    endfunction

    task automatic check_eq(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // memory side: random ready, refill a few cycles after the read command
    always @(negedge clk) begin : responder
        int base;
        mem_resp_valid_i = (resp_delay == 0);
        if (resp_delay >= 0) begin
            resp_delay--;
        end
        mem_req_ready_i = (next_rand(mem_seed) % 3) != 0;  // withheld a third of the time
        if (stalled) begin
            check_eq("resp_valid_o", 0, resp_valid_o);
        end
        stalled = (mem_req_valid_o === 1'b1) && !mem_req_ready_i;
        if (mem_req_valid_o === 1'b1 && mem_req_ready_i) begin
            base = byte_index(mem_req_addr_o);
            if (mem_req_addr_o[31:11] >= N_TAGS || mem_req_addr_o[10:4] >= N_SETS ||
                mem_req_addr_o[3:0] != 4'h0) begin
                errors++;
                $display("memory command to address %h outside the tested lines",
                         mem_req_addr_o);
            end else begin
                cmd_write_q.push_back(mem_req_write_o);
                cmd_addr_q.push_back(mem_req_addr_o);
                if (mem_req_write_o) begin
                    check_eq("mem_req_wdata_o", get_line(model_mem, base), mem_req_wdata_o);
                    for (int b = 0; b < 16; b++) begin
                        ram[base + b] = mem_req_wdata_o[b*8 +: 8];
                    end
                end else begin
                    mem_resp_rdata_i = get_line(ram, base);
                    resp_delay       = int'(next_rand(mem_seed) % 4) + 1;
                end
            end
        end
    end

    // one cpu access, predicted by the shadow tags and checked on the response
    task automatic run_access();
        logic [31:0]                 addr;
        logic                        wr;
        logic [63:0]                 wd;
        logic [7:0]                  st;
        logic [63:0]                 exp_rdata;
        logic                        hit;
        logic                        wb;
        dcache_geom_pkg::way_t       way;
        dcache_geom_pkg::tag_entry_t vic;
        int                          t;
        int                          s;
        int                          base;
        int                          waited;

        repeat (next_rand(cpu_seed) % 3) @(negedge clk);
        t    = int'(next_rand(cpu_seed) % N_TAGS);
        s    = int'(next_rand(cpu_seed) % N_SETS);
        addr = {21'(t), 7'(s), 1'(next_rand(cpu_seed) % 2), 3'b000};
        wr   = (next_rand(cpu_seed) % 2) == 1;
        wd   = {next_rand(cpu_seed), next_rand(cpu_seed), next_rand(cpu_seed),
                next_rand(cpu_seed)};
        st   = 8'(next_rand(cpu_seed));
        base = byte_index(addr);

        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (shadow[s][w].valid && shadow[s][w].tag == addr[31:11]) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            way = !shadow[s][0].valid ? 1'b0 : !shadow[s][1].valid ? 1'b1 : ~mru[s];
        end
        vic = shadow[s][way];
        wb  = !hit && vic.valid && vic.dirty;
        for (int b = 0; b < 8; b++) begin
            if (wr && st[b]) begin
                model_mem[base + b] = wd[b*8 +: 8];
            end
            exp_rdata[b*8 +: 8] = model_mem[base + b];
        end

        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_wdata_i = wd;
        req_strb_i  = st;
        waited      = 0;
        while (!req_ready_o && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready_o) begin
            errors++;
            stop = 1'b1;
            $display("cache never raised req_ready_o within 50 cycles");
            return;
        end
        @(negedge clk);  // accepted on the edge just passed
        req_valid_i = 1'b0;
        check_eq("resp_valid_o", hit, resp_valid_o);
        waited = 0;
        while (!resp_valid_o && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!resp_valid_o) begin
            errors++;
            stop = 1'b1;
            $display("no response to a miss within 200 cycles");
            return;
        end
        if (!wr) begin
            check_eq("resp_rdata_o", exp_rdata, resp_rdata_o);
        end

        check_eq("mem_req_valid_o transfers", hit ? 0 : 1 + wb, cmd_write_q.size());
        if (wb && cmd_write_q.size() > 0) begin
            check_eq("mem_req_write_o", 1, cmd_write_q.pop_front());
            check_eq("mem_req_addr_o", {vic.tag, 7'(s), 4'h0}, cmd_addr_q.pop_front());
        end
        if (!hit && cmd_write_q.size() > 0) begin
            check_eq("mem_req_write_o", 0, cmd_write_q.pop_front());
            check_eq("mem_req_addr_o", {addr[31:4], 4'h0}, cmd_addr_q.pop_front());
        end
        cmd_write_q.delete();
        cmd_addr_q.delete();

        if (hit) begin
            shadow[s][way].dirty = shadow[s][way].dirty | wr;
        end else begin
            shadow[s][way] = '{tag: addr[31:11], valid: 1'b1, dirty: wr};
        end
        mru[s] = way;
    endtask

    initial begin
        rst              = 1'b1;
        req_valid_i      = 1'b0;
        req_write_i      = 1'b0;
        req_addr_i       = '0;
        req_wdata_i      = '0;
        req_strb_i       = '0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_rdata_i = '0;
        cpu_seed         = 32'd60;
        mem_seed         = 32'd60 ^ 32'h0000_a5a5;  // separate stream for the responder
        resp_delay       = -1;
        stalled          = 1'b0;
        errors           = 0;
        checks           = 0;
        stop             = 1'b0;
        shadow           = '{default: '0};
        mru              = '{default: 1'b0};
        for (int i = 0; i < N_BYTES; i++) begin
            ram[i]       = fill_byte(((i / 64) << 11) | (((i / 16) % 4) << 4) | (i % 16));
            model_mem[i] = ram[i];
        end

        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_eq("req_ready_o", 1, req_ready_o);
        check_eq("resp_valid_o", 0, resp_valid_o);
        check_eq("mem_req_valid_o", 0, mem_req_valid_o);

        for (int n = 0; n < N_ACCESS && !stop; n++) begin
            run_access();
        end

        errors += dcache_top_i.ctrl_i.chk_i.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/data_sram.sv ====
`timescale 1ns/100ps

// line-wide data store for one way
// single port: each enabled cycle is either a masked write or a read
module data_sram #(
    parameter int  SETS_P = dcache_geom_pkg::SETS,
    localparam int IDX_W  = $clog2(SETS_P)
) (
    input  logic                                   clk,
    input  logic                                   en_i,
    input  logic                                   we_i,
    input  logic [IDX_W-1:0]                       addr_i,
    input  logic [dcache_bus_pkg::LINE_STRB_W-1:0] wmask_i,
    input  logic [dcache_geom_pkg::LINE_W-1:0]     wdata_i,
    output logic [dcache_geom_pkg::LINE_W-1:0]     rdata_o
);

    logic [dcache_geom_pkg::LINE_W-1:0] mem [SETS_P];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                // byte lanes
                for (int b = 0; b < dcache_bus_pkg::LINE_STRB_W; b++) begin
                    if (wmask_i[b]) begin
                        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[addr_i];  // held until the next read
            end
        end
    end

endmodule

// ==== hw/dcache_bus_pkg.sv ====
package dcache_bus_pkg;

    // load/store unit side
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    // byte mask of a full line write into a data store
    localparam int LINE_STRB_W = 2 * STRB_W;

    // controller states
    // one request in flight, so no overlap between them
    typedef enum logic [2:0] {
        IDLE        = 3'd0,  // ready for a request
        LOOKUP      = 3'd1,  // hit, respond and update
        WRITEBACK   = 3'd2,  // dirty victim goes out first
        REFILL_REQ  = 3'd3,  // line read command
        REFILL_WAIT = 3'd4,  // waiting on the returned line
        RESPOND     = 3'd5   // miss finished
    } ctrl_state_t;

endpackage

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int  SETS_P = dcache_geom_pkg::SETS,
    localparam int IDX_W  = $clog2(SETS_P)
) (
    input  logic                                   clk,
    input  logic                                   rst,

    // load/store unit
    input  logic                                   req_valid_i,
    output logic                                   req_ready_o,
    input  logic                                   req_write_i,
    input  logic [dcache_geom_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic [dcache_bus_pkg::DATA_W-1:0]      req_wdata_i,
    input  logic [dcache_bus_pkg::STRB_W-1:0]      req_strb_i,
    output logic                                   resp_valid_o,
    output logic [dcache_bus_pkg::DATA_W-1:0]      resp_rdata_o,

    // memory, one line per beat
    output logic                                   mem_req_valid_o,
    input  logic                                   mem_req_ready_i,
    output logic                                   mem_req_write_o,
    output logic [dcache_geom_pkg::ADDR_W-1:0]     mem_req_addr_o,
    output logic [dcache_geom_pkg::LINE_W-1:0]     mem_req_wdata_o,
    input  logic                                   mem_resp_valid_i,
    input  logic [dcache_geom_pkg::LINE_W-1:0]     mem_resp_rdata_i,

    // tag arrays
    output logic [IDX_W-1:0]                       tag_rd_idx_o,
    input  dcache_geom_pkg::tag_entry_t            tag0_rd_i,
    input  dcache_geom_pkg::tag_entry_t            tag1_rd_i,
    output logic [IDX_W-1:0]                       tag_wr_idx_o,
    output dcache_geom_pkg::tag_entry_t            tag_wr_data_o,
    output logic                                   tag0_wr_en_o,
    output logic                                   tag1_wr_en_o,

    // recency array, indexed like the tags
    input  dcache_geom_pkg::way_t                  lru_rd_i,
    output logic                                   lru_wr_en_o,
    output dcache_geom_pkg::way_t                  lru_wr_data_o,

    // data stores
    output logic [dcache_geom_pkg::WAYS-1:0]       sram_en_o,
    output logic                                   sram_we_o,
    output logic [IDX_W-1:0]                       sram_addr_o,
    output logic [dcache_bus_pkg::LINE_STRB_W-1:0] sram_wmask_o,
    output logic [dcache_geom_pkg::LINE_W-1:0]     sram_wdata_o,
    input  logic [dcache_geom_pkg::LINE_W-1:0]     sram0_rdata_i,
    input  logic [dcache_geom_pkg::LINE_W-1:0]     sram1_rdata_i
);

    localparam int ADDR_W   = dcache_geom_pkg::ADDR_W;
    localparam int OFFSET_W = dcache_geom_pkg::OFFSET_W;
    localparam int TAG_W    = dcache_geom_pkg::TAG_W;
    localparam int LINE_W   = dcache_geom_pkg::LINE_W;
    localparam int DATA_W   = dcache_bus_pkg::DATA_W;
    localparam int STRB_W   = dcache_bus_pkg::STRB_W;
    localparam int TAG_LSB  = OFFSET_W + dcache_geom_pkg::INDEX_W;
    localparam int WORD_BIT = OFFSET_W - 1;  // picks the 64-bit half of a line

    dcache_bus_pkg::ctrl_state_t state_q, state_d;

    // request buffer
    logic [ADDR_W-1:0]     addr_q;
    logic                  write_q;
    logic [DATA_W-1:0]     wdata_q;
    logic [STRB_W-1:0]     strb_q;

    // lookup results, captured on accept
    dcache_geom_pkg::way_t hit_way_q;
    dcache_geom_pkg::way_t victim_q;
    logic [TAG_W-1:0]      victim_tag_q;
    logic [DATA_W-1:0]     fill_word_q;

    logic                        accept;
    logic [IDX_W-1:0]            req_idx;
    logic [TAG_W-1:0]            req_tag;
    logic                        hit0;
    logic                        hit1;
    dcache_geom_pkg::way_t       victim;
    dcache_geom_pkg::tag_entry_t victim_entry;
    logic [IDX_W-1:0]            idx_q;
    logic [TAG_W-1:0]            tag_q;
    logic [ADDR_W-1:0]           idx_addr;
    logic                        write_hit;
    logic                        refill_done;
    dcache_geom_pkg::way_t       way_used;
    logic [dcache_geom_pkg::WAYS-1:0] way_sel;
    logic [dcache_bus_pkg::LINE_STRB_W-1:0] line_mask;
    logic [LINE_W-1:0]           line_wdata;
    logic [LINE_W-1:0]           fill_line;
    logic [LINE_W-1:0]           hit_line;

    function automatic logic [DATA_W-1:0] pick_word(input logic [LINE_W-1:0] line,
                                                    input logic upper);
        return upper ? line[LINE_W-1 -: DATA_W] : line[DATA_W-1:0];
    endfunction

    assign accept  = req_valid_i && req_ready_o;
    assign req_idx = req_addr_i[OFFSET_W +: IDX_W];
    assign req_tag = req_addr_i[ADDR_W-1:TAG_LSB];

    // tag compare on the combinational array read
    assign hit0 = tag0_rd_i.valid && (tag0_rd_i.tag == req_tag);
    assign hit1 = tag1_rd_i.valid && (tag1_rd_i.tag == req_tag);

    // invalid way first, else the one not recently used
    always_comb begin
        if (!tag0_rd_i.valid) begin
            victim = 1'b0;
        end else if (!tag1_rd_i.valid) begin
            victim = 1'b1;
        end else begin
            victim = ~lru_rd_i;
        end
    end
    assign victim_entry = victim ? tag1_rd_i : tag0_rd_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_bus_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= req_addr_i;
            write_q      <= req_write_i;
            wdata_q      <= req_wdata_i;
            strb_q       <= req_strb_i;
            hit_way_q    <= hit1;
            victim_q     <= victim;
            victim_tag_q <= victim_entry.tag;
        end
        if (refill_done) begin
            fill_word_q <= pick_word(fill_line, addr_q[WORD_BIT]);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_bus_pkg::IDLE: begin
                if (accept) begin
                    if (hit0 || hit1) begin
                        state_d = dcache_bus_pkg::LOOKUP;
                    end else if (victim_entry.valid && victim_entry.dirty) begin
                        state_d = dcache_bus_pkg::WRITEBACK;
                    end else begin
                        state_d = dcache_bus_pkg::REFILL_REQ;
                    end
                end
            end
            dcache_bus_pkg::LOOKUP:      state_d = dcache_bus_pkg::IDLE;
            dcache_bus_pkg::WRITEBACK: begin
                if (mem_req_ready_i) state_d = dcache_bus_pkg::REFILL_REQ;
            end
            dcache_bus_pkg::REFILL_REQ: begin
                if (mem_req_ready_i) state_d = dcache_bus_pkg::REFILL_WAIT;
            end
            dcache_bus_pkg::REFILL_WAIT: begin
                if (mem_resp_valid_i) state_d = dcache_bus_pkg::RESPOND;
            end
            dcache_bus_pkg::RESPOND:     state_d = dcache_bus_pkg::IDLE;
            default:                     state_d = dcache_bus_pkg::IDLE;
        endcase
    end

    assign idx_q       = addr_q[OFFSET_W +: IDX_W];
    assign tag_q       = addr_q[ADDR_W-1:TAG_LSB];
    assign write_hit   = (state_q == dcache_bus_pkg::LOOKUP) && write_q;
    assign refill_done = (state_q == dcache_bus_pkg::REFILL_WAIT) && mem_resp_valid_i;
    assign way_used    = (state_q == dcache_bus_pkg::LOOKUP) ? hit_way_q : victim_q;

    always_comb begin
        way_sel           = '0;
        way_sel[way_used] = 1'b1;
    end

    // strobes placed into the addressed half of the line
    assign line_mask  = addr_q[WORD_BIT] ? {strb_q, {STRB_W{1'b0}}}
                                         : {{STRB_W{1'b0}}, strb_q};
    assign line_wdata = {wdata_q, wdata_q};

    // refill line with a pending store merged over it
    always_comb begin
        for (int b = 0; b < dcache_bus_pkg::LINE_STRB_W; b++) begin
            fill_line[b*8 +: 8] = (write_q && line_mask[b]) ? line_wdata[b*8 +: 8]
                                                            : mem_resp_rdata_i[b*8 +: 8];
        end
    end

    // cpu side
    assign hit_line     = hit_way_q ? sram1_rdata_i : sram0_rdata_i;
    assign req_ready_o  = (state_q == dcache_bus_pkg::IDLE);
    assign resp_valid_o = (state_q == dcache_bus_pkg::LOOKUP) ||
                          (state_q == dcache_bus_pkg::RESPOND);
    assign resp_rdata_o = (state_q == dcache_bus_pkg::LOOKUP)
                        ? pick_word(hit_line, addr_q[WORD_BIT]) : fill_word_q;

    // memory side, victim line is still on the store output from the accept read
    assign idx_addr = {{(ADDR_W-IDX_W-OFFSET_W){1'b0}}, idx_q, {OFFSET_W{1'b0}}};
    assign mem_req_valid_o = (state_q == dcache_bus_pkg::WRITEBACK) ||
                             (state_q == dcache_bus_pkg::REFILL_REQ);
    assign mem_req_write_o = (state_q == dcache_bus_pkg::WRITEBACK);
    assign mem_req_addr_o  = mem_req_write_o
                           ? ({victim_tag_q, {TAG_LSB{1'b0}}} | idx_addr)
                           : {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_req_wdata_o = victim_q ? sram1_rdata_i : sram0_rdata_i;

    // tag and recency updates
    assign tag_rd_idx_o  = req_idx;
    assign tag_wr_idx_o  = idx_q;
    assign tag_wr_data_o = '{tag: tag_q, valid: 1'b1, dirty: write_q};
    assign tag0_wr_en_o  = (write_hit || refill_done) && (way_used == 1'b0);
    assign tag1_wr_en_o  = (write_hit || refill_done) && (way_used == 1'b1);
    assign lru_wr_en_o   = (state_q == dcache_bus_pkg::LOOKUP) || refill_done;
    assign lru_wr_data_o = way_used;

    // both ways read on accept, one way written on a store hit or refill
    assign sram_en_o    = (state_q == dcache_bus_pkg::IDLE) ? {dcache_geom_pkg::WAYS{req_valid_i}}
                        : (write_hit || refill_done) ? way_sel : '0;
    assign sram_we_o    = write_hit || refill_done;
    assign sram_addr_o  = (state_q == dcache_bus_pkg::IDLE) ? req_idx : idx_q;
    assign sram_wmask_o = refill_done ? '1 : line_mask;
    assign sram_wdata_o = refill_done ? fill_line : line_wdata;

endmodule

// ==== hw/dcache_geom_pkg.sv ====
package dcache_geom_pkg;

    // byte address and its split into tag / index / offset
    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;   // 16-byte lines
    localparam int INDEX_W  = 7;   // set index, bits 10:4
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // bits 31:11

    // organisation
    localparam int SETS   = 1 << INDEX_W;
    localparam int WAYS   = 2;
    localparam int LINE_W = 8 << OFFSET_W;   // 128 bits per line

    // one tag array entry, 23 bits
    // laid out as tag, valid, dirty from msb down
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
    } tag_entry_t;

    // names one of the two ways
    // also the per-set recency entry
    typedef logic way_t;

endpackage

// ==== hw/dcache_top.sv ====
`timescale 1ns/100ps

// two-way write-back data cache
module dcache_top #(
    parameter int  SETS_P = dcache_geom_pkg::SETS,
    localparam int IDX_W  = $clog2(SETS_P)
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               req_valid_i,
    output logic                               req_ready_o,
    input  logic                               req_write_i,
    input  logic [dcache_geom_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [dcache_bus_pkg::DATA_W-1:0]  req_wdata_i,
    input  logic [dcache_bus_pkg::STRB_W-1:0]  req_strb_i,
    output logic                               resp_valid_o,
    output logic [dcache_bus_pkg::DATA_W-1:0]  resp_rdata_o,

    output logic                               mem_req_valid_o,
    input  logic                               mem_req_ready_i,
    output logic                               mem_req_write_o,
    output logic [dcache_geom_pkg::ADDR_W-1:0] mem_req_addr_o,
    output logic [dcache_geom_pkg::LINE_W-1:0] mem_req_wdata_o,
    input  logic                               mem_resp_valid_i,
    input  logic [dcache_geom_pkg::LINE_W-1:0] mem_resp_rdata_i
);

    logic [IDX_W-1:0]                       tag_rd_idx;
    logic [IDX_W-1:0]                       tag_wr_idx;
    dcache_geom_pkg::tag_entry_t            tag0_rd;
    dcache_geom_pkg::tag_entry_t            tag1_rd;
    dcache_geom_pkg::tag_entry_t            tag_wr_data;
    logic                                   tag0_wr_en;
    logic                                   tag1_wr_en;
    dcache_geom_pkg::way_t                  lru_rd;
    dcache_geom_pkg::way_t                  lru_wr_data;
    logic                                   lru_wr_en;
    logic [dcache_geom_pkg::WAYS-1:0]       sram_en;
    logic                                   sram_we;
    logic [IDX_W-1:0]                       sram_addr;
    logic [dcache_bus_pkg::LINE_STRB_W-1:0] sram_wmask;
    logic [dcache_geom_pkg::LINE_W-1:0]     sram_wdata;
    logic [dcache_geom_pkg::LINE_W-1:0]     sram0_rdata;
    logic [dcache_geom_pkg::LINE_W-1:0]     sram1_rdata;

    dcache_ctrl #(.SETS_P(SETS_P)) ctrl_i (
        .clk, .rst,
        .req_valid_i, .req_ready_o, .req_write_i, .req_addr_i, .req_wdata_i, .req_strb_i,
        .resp_valid_o, .resp_rdata_o,
        .mem_req_valid_o, .mem_req_ready_i, .mem_req_write_o, .mem_req_addr_o,
        .mem_req_wdata_o, .mem_resp_valid_i, .mem_resp_rdata_i,
        .tag_rd_idx_o (tag_rd_idx),  .tag0_rd_i (tag0_rd),  .tag1_rd_i (tag1_rd),
        .tag_wr_idx_o (tag_wr_idx),  .tag_wr_data_o (tag_wr_data),
        .tag0_wr_en_o (tag0_wr_en),  .tag1_wr_en_o (tag1_wr_en),
        .lru_rd_i     (lru_rd),      .lru_wr_en_o (lru_wr_en), .lru_wr_data_o (lru_wr_data),
        .sram_en_o    (sram_en),     .sram_we_o (sram_we),     .sram_addr_o (sram_addr),
        .sram_wmask_o (sram_wmask),  .sram_wdata_o (sram_wdata),
        .sram0_rdata_i (sram0_rdata), .sram1_rdata_i (sram1_rdata)
    );

    // tag / valid / dirty per way
    line_regs #(.entry_t(dcache_geom_pkg::tag_entry_t), .SETS_P(SETS_P)) tag0_i (
        .clk, .rst, .wr_en_i (tag0_wr_en), .wr_idx_i (tag_wr_idx), .wr_data_i (tag_wr_data),
        .rd_idx_i (tag_rd_idx), .rd_data_o (tag0_rd)
    );

    line_regs #(.entry_t(dcache_geom_pkg::tag_entry_t), .SETS_P(SETS_P)) tag1_i (
        .clk, .rst, .wr_en_i (tag1_wr_en), .wr_idx_i (tag_wr_idx), .wr_data_i (tag_wr_data),
        .rd_idx_i (tag_rd_idx), .rd_data_o (tag1_rd)
    );

    // most recently used way per set
    line_regs #(.entry_t(dcache_geom_pkg::way_t), .SETS_P(SETS_P)) lru_i (
        .clk, .rst, .wr_en_i (lru_wr_en), .wr_idx_i (tag_wr_idx), .wr_data_i (lru_wr_data),
        .rd_idx_i (tag_rd_idx), .rd_data_o (lru_rd)
    );

    data_sram #(.SETS_P(SETS_P)) sram0_i (
        .clk, .en_i (sram_en[0]), .we_i (sram_we), .addr_i (sram_addr),
        .wmask_i (sram_wmask), .wdata_i (sram_wdata), .rdata_o (sram0_rdata)
    );

    data_sram #(.SETS_P(SETS_P)) sram1_i (
        .clk, .en_i (sram_en[1]), .we_i (sram_we), .addr_i (sram_addr),
        .wmask_i (sram_wmask), .wdata_i (sram_wdata), .rdata_o (sram1_rdata)
    );

endmodule

// ==== hw/line_regs.sv ====
`timescale 1ns/100ps

// one entry per set, held in flops
// read is combinational so the controller sees it in the accept cycle
module line_regs #(
    parameter type    entry_t = dcache_geom_pkg::tag_entry_t,
    parameter int     SETS_P  = dcache_geom_pkg::SETS,
    localparam int    IDX_W   = $clog2(SETS_P)
) (
    input  logic             clk,
    input  logic             rst,

    // write port
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  entry_t           wr_data_i,

    // read port
    input  logic [IDX_W-1:0] rd_idx_i,
    output entry_t           rd_data_o
);

    entry_t regs_q [SETS_P];

    // all entries start invalid / way 0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SETS_P; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // same-cycle write is not forwarded, old value comes out
    assign rd_data_o = regs_q[rd_idx_i];

endmodule
